// File: common/stb_gen_defines.svh
/* width and reset value macros for the strobe generator,
   APB bus widths and register byte offsets */
`ifndef STB_GEN_DEFINES_SVH
`define STB_GEN_DEFINES_SVH

// cycle counter and measured period
`define STB_CNT_WIDTH 16

// low phase of the strobe
`define STB_HOLD_WIDTH 8
`define STB_HOLD_DEFAULT 5

// APB bus
`define APB_ADDR_WIDTH 4
`define APB_DATA_WIDTH 32

// register byte offsets
`define REG_CTRL 0
`define REG_HOLD 4
`define REG_STATUS 8
`define REG_PERIOD 12

`endif

// File: common/stb_pkg.sv
/* measurement state enum, config and status structs */
`include "stb_gen_defines.svh"

package stb_pkg;

   // measurement and generation states
   typedef enum logic [1:0] {
      ST_GEN,
      ST_WAIT_FIRST,
      ST_MEASURE
   } stb_state_e;

   // host configuration, 9 bits
   typedef struct packed {
      logic                       oe;
      logic [`STB_HOLD_WIDTH-1:0] hold;
   } stb_cfg_t;

   // status word, rdy lands in bit 0
   typedef struct packed {
      logic valid;
      logic err;
      logic rdy;
   } stb_status_t;

endpackage

// File: common/apb_pkg.sv
/* APB request and response structs, register address enum */
`include "stb_gen_defines.svh"

package apb_pkg;

   typedef struct packed {
      logic                       psel;
      logic                       penable;
      logic                       pwrite;
      logic [`APB_ADDR_WIDTH-1:0] paddr;
      logic [`APB_DATA_WIDTH-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [`APB_DATA_WIDTH-1:0] prdata;
      logic                       pready;
      logic                       pslverr;
   } apb_rsp_t;

   // mapped register offsets
   typedef enum logic [`APB_ADDR_WIDTH-1:0] {
      ADDR_CTRL   = `REG_CTRL,
      ADDR_HOLD   = `REG_HOLD,
      ADDR_STATUS = `REG_STATUS,
      ADDR_PERIOD = `REG_PERIOD
   } apb_reg_e;

endpackage

// File: rtl/apb_regs.sv
/* APB slave with CTRL, HOLD, STATUS and PERIOD registers,
   run pulse generation */
`timescale 1ns/10ps
`include "stb_gen_defines.svh"

module apb_regs
   import stb_pkg::*, apb_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_i,
   input  apb_req_t                  apb_req_i,
   output apb_rsp_t                  apb_rsp_o,
   input  stb_status_t               status_i,
   input  logic [`STB_CNT_WIDTH-1:0] period_i,
   output stb_cfg_t                  cfg_o,
   output logic                      run_o
);

   logic                       access;
   logic                       wr_en;
   logic                       rd_en;
   logic                       hit;
   apb_reg_e                   addr;
   logic                       oe_q;
   logic [`STB_HOLD_WIDTH-1:0] hold_q;
   logic                       run_q;
   logic [`APB_DATA_WIDTH-1:0] rdata;

   // access phase, no wait states
   assign access = apb_req_i.psel & apb_req_i.penable;
   assign wr_en  = access & apb_req_i.pwrite;
   assign rd_en  = access & ~apb_req_i.pwrite;
   assign addr   = apb_reg_e'(apb_req_i.paddr);

   always_comb begin
      hit = 1'b1;
      case (addr)
         ADDR_CTRL, ADDR_HOLD, ADDR_STATUS, ADDR_PERIOD: hit = 1'b1;
         default: hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         oe_q   <= 1'b0;
         hold_q <= `STB_HOLD_WIDTH'(`STB_HOLD_DEFAULT);
         run_q  <= 1'b0;
      end else begin
         // run is a one-cycle strobe, never stored
         run_q <= 1'b0;
         if (wr_en) begin
            case (addr)
               ADDR_CTRL: begin
                  oe_q  <= apb_req_i.pwdata[0];
                  run_q <= apb_req_i.pwdata[1];
               end
               ADDR_HOLD: hold_q <= apb_req_i.pwdata[`STB_HOLD_WIDTH-1:0];
               default: ;
            endcase
         end
      end
   end

   // read mux, zero outside a read access
   always_comb begin
      rdata = '0;
      if (rd_en) begin
         case (addr)
            ADDR_CTRL:   rdata[0] = oe_q;
            ADDR_HOLD:   rdata[`STB_HOLD_WIDTH-1:0] = hold_q;
            ADDR_STATUS: rdata[2:0] = status_i;
            ADDR_PERIOD: rdata[`STB_CNT_WIDTH-1:0] = period_i;
            default:     rdata = '0;
         endcase
      end
   end

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = access & ~hit;

   assign cfg_o.oe   = oe_q;
   assign cfg_o.hold = hold_q;
   assign run_o      = run_q;

   // back-to-back CTRL writes still give separate pulses
   a_run_single : assert property (
      @(posedge clk_i) disable iff (arst_i) run_o |=> !run_o
   );

endmodule

// File: stb_core/stb_fsm.sv
/* measurement and generation state machine,
   overflow error and valid flag tracking */
`timescale 1ns/10ps

module stb_fsm
   import stb_pkg::*;
(
   input  logic        clk_i,
   input  logic        arst_i,
   input  logic        run_i,
   input  logic        edge_i,
   input  logic        cnt_sat_i,
   input  logic        wrap_i,
   output stb_status_t status_o,
   output logic        cnt_clr_o,
   output logic        load_period_o,
   output logic        gen_en_o
);

   stb_state_e state_q;
   stb_state_e state_d;
   logic       err_q;
   logic       err_d;
   logic       valid_q;
   logic       valid_d;

   always_comb begin
      state_d       = state_q;
      err_d         = err_q;
      valid_d       = valid_q;
      cnt_clr_o     = 1'b0;
      load_period_o = 1'b0;
      if (run_i) begin
         // restart from any state
         state_d   = ST_WAIT_FIRST;
         err_d     = 1'b0;
         valid_d   = 1'b0;
         cnt_clr_o = 1'b1;
      end else begin
         case (state_q)
            ST_WAIT_FIRST: begin
               if (cnt_sat_i) begin
                  state_d = ST_GEN;
                  err_d   = 1'b1;
               end else if (edge_i) begin
                  state_d   = ST_MEASURE;
                  cnt_clr_o = 1'b1;
               end
            end
            ST_MEASURE: begin
               // saturation wins, the period would not fit
               if (cnt_sat_i) begin
                  state_d = ST_GEN;
                  err_d   = 1'b1;
               end else if (edge_i) begin
                  state_d       = ST_GEN;
                  valid_d       = 1'b1;
                  load_period_o = 1'b1;
                  cnt_clr_o     = 1'b1;
               end
            end
            default: begin
               if (valid_q && wrap_i)
                  cnt_clr_o = 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ST_GEN;
         err_q   <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         err_q   <= err_d;
         valid_q <= valid_d;
      end
   end

   assign status_o.rdy   = (state_q == ST_GEN);
   assign status_o.err   = err_q;
   assign status_o.valid = valid_q;
   assign gen_en_o       = (state_q == ST_GEN) & valid_q;

   // a captured period is never followed by a fresh overflow
   a_load_no_err : assert property (
      @(posedge clk_i) disable iff (arst_i) load_period_o |=> !$rose(err_q)
   );

endmodule

// File: stb_core/period_timer.sv
/* input synchronizer, rising edge detect and saturating counter */
`timescale 1ns/10ps
`include "stb_gen_defines.svh"

module period_timer (
   input  logic                      clk_i,
   input  logic                      arst_i,
   input  logic                      sig_i,
   input  logic                      clr_i,
   output logic                      edge_o,
   output logic [`STB_CNT_WIDTH-1:0] cnt_o,
   output logic                      cnt_sat_o
);

   logic                      sync1_q;
   logic                      sync2_q;
   logic                      prev_q;
   logic [`STB_CNT_WIDTH-1:0] cnt_q;

   // two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         sync1_q <= 1'b0;
         sync2_q <= 1'b0;
         prev_q  <= 1'b0;
      end else begin
         sync1_q <= sig_i;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
      end
   end

   assign edge_o    = sync2_q & ~prev_q;
   assign cnt_sat_o = &cnt_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i)
         cnt_q <= '0;
      else if (clr_i)
         cnt_q <= '0;
      else if (!cnt_sat_o)
         cnt_q <= cnt_q + 1'b1;
   end

   assign cnt_o = cnt_q;

   a_no_wrap : assert property (
      @(posedge clk_i) disable iff (arst_i) (cnt_sat_o && !clr_i) |=> cnt_sat_o
   );

endmodule

// File: stb_core/period_capture.sv
/* measured period register, wrap detect and strobe shaping */
`timescale 1ns/10ps
`include "stb_gen_defines.svh"

module period_capture
   import stb_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      arst_i,
   input  logic                      load_i,
   input  logic                      gen_en_i,
   input  logic [`STB_CNT_WIDTH-1:0] cnt_i,
   input  stb_cfg_t                  cfg_i,
   output logic [`STB_CNT_WIDTH-1:0] period_o,
   output logic                      wrap_o,
   output logic                      stb_o
);

   logic [`STB_CNT_WIDTH-1:0] period_q;
   logic [`STB_CNT_WIDTH-1:0] hold_ext;
   logic                      low_phase;
   logic                      stb_q;

   // counter was cleared on the first edge, so it reads N-1 at the second
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i)
         period_q <= '0;
      else if (load_i)
         period_q <= cnt_i + 1'b1;
   end

   assign hold_ext = {{(`STB_CNT_WIDTH-`STB_HOLD_WIDTH){1'b0}}, cfg_i.hold};

   assign wrap_o = gen_en_i & (cnt_i == period_q - 1'b1);

   // hold of N or more keeps the strobe low all period
   assign low_phase = (hold_ext >= period_q) | (cnt_i >= period_q - hold_ext);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i)
         stb_q <= 1'b0;
      else
         stb_q <= gen_en_i & cfg_i.oe & ~low_phase;
   end

   assign period_o = period_q;
   assign stb_o    = stb_q;

endmodule

// File: rtl/stb_gen_top.sv
/* strobe generator top, register block, FSM, timer and capture */
`timescale 1ns/10ps
`include "stb_gen_defines.svh"

module stb_gen_top
   import stb_pkg::*, apb_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_i,
   input  apb_req_t apb_req_i,
   output apb_rsp_t apb_rsp_o,
   input  logic     sig_i,
   output logic     stb_o,
   output logic     rdy_o,
   output logic     err_o
);

   stb_cfg_t                  cfg;
   stb_status_t               status;
   logic                      run_pulse;
   logic                      cnt_clr;
   logic                      load_period;
   logic                      gen_en;
   logic                      edge_det;
   logic                      cnt_sat;
   logic                      wrap;
   logic [`STB_CNT_WIDTH-1:0] cnt;
   logic [`STB_CNT_WIDTH-1:0] period;

   apb_regs i_apb_regs (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .status_i  (status),
      .period_i  (period),
      .cfg_o     (cfg),
      .run_o     (run_pulse)
   );

   stb_fsm i_stb_fsm (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .run_i         (run_pulse),
      .edge_i        (edge_det),
      .cnt_sat_i     (cnt_sat),
      .wrap_i        (wrap),
      .status_o      (status),
      .cnt_clr_o     (cnt_clr),
      .load_period_o (load_period),
      .gen_en_o      (gen_en)
   );

   period_timer i_period_timer (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .sig_i     (sig_i),
      .clr_i     (cnt_clr),
      .edge_o    (edge_det),
      .cnt_o     (cnt),
      .cnt_sat_o (cnt_sat)
   );

   period_capture i_period_capture (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .load_i   (load_period),
      .gen_en_i (gen_en),
      .cnt_i    (cnt),
      .cfg_i    (cfg),
      .period_o (period),
      .wrap_o   (wrap),
      .stb_o    (stb_o)
   );

   assign rdy_o = status.rdy;
   assign err_o = status.err;

endmodule

// File: sim/tb_stb_gen.sv
/* testbench for the strobe generator, random periods checked against
   a model, APB access tasks and a watchdog */
`timescale 1ns/10ps
`include "stb_gen_defines.svh"

module tb_stb_gen
   import apb_pkg::*;
();

   localparam int TRIALS          = 12;
   localparam int WATCHDOG_CYCLES = TRIALS * (8 * 60 + 200) + 2 * 65536;

   logic     clk;
   logic     arst;
   logic     sig;
   logic     stb;
   logic     rdy;
   logic     err;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   // model of the register contents
   int          m_oe;
   int          m_hold;
   int          m_period;
   int          seed;
   int          errors;
   int          checks;
   int          sig_period;
   int          phase;
   int          n;
   int          hold;
   int          t;
   logic        slverr;
   logic [31:0] rdata;

   stb_gen_top i_stb_gen_top (
      .clk_i     (clk),
      .arst_i    (arst),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp),
      .sig_i     (sig),
      .stb_o     (stb),
      .rdy_o     (rdy),
      .err_o     (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // square wave on sig held low while the period is 0
   always @(posedge clk) begin
      if (sig_period == 0) begin
         phase = 0;
         sig <= 1'b0;
      end else begin
         sig <= (phase < sig_period / 2);
         phase = (phase + 1) % sig_period;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   // STATUS has rdy in bit 0, err in bit 1 and valid in bit 2
   function automatic int status_word(input int rdy_v, input int err_v, input int valid_v);
      return valid_v * 4 + err_v * 2 + rdy_v;
   endfunction

   task automatic check_eq(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // setup phase then one access phase without wait states
   task automatic apb_access(input logic wr, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [`APB_DATA_WIDTH-1:0] wdata,
                             output logic [`APB_DATA_WIDTH-1:0] data, output logic slv);
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      // response settles during the access phase
      @(negedge clk);
      data = apb_rsp.prdata;
      slv  = apb_rsp.pslverr;
      check_eq("pready in the access phase", int'(apb_rsp.pready), 1);
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] wdata);
      logic [31:0] data;
      logic        slv;
      apb_access(1'b1, addr, wdata, data, slv);
      check_eq("pslverr on write", int'(slv), 0);
   endtask

   task automatic expect_reg(input string what, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input int exp);
      logic [31:0] data;
      logic        slv;
      apb_access(1'b0, addr, 32'd0, data, slv);
      check_eq({what, " pslverr"}, int'(slv), 0);
      check_eq(what, int'(data), exp);
   endtask

   // start a measurement with oe set and wait for rdy to fall and rise again
   task automatic run_measure(input int limit);
      int cnt;
      int stb_high;
      cnt      = 0;
      stb_high = 0;
      write_reg(ADDR_CTRL, 32'd3);
      m_oe = 1;
      while (rdy !== 1'b0 && cnt < 4) begin
         @(negedge clk);
         cnt++;
      end
      if (rdy !== 1'b0) begin
         errors++;
         $display("rdy_o did not drop after the run command");
      end
      cnt = 0;
      while (rdy !== 1'b1 && cnt < limit) begin
         @(negedge clk);
         cnt++;
         if (stb !== 1'b0)
            stb_high++;
      end
      if (rdy !== 1'b1) begin
         errors++;
         $display("measurement still running after %0d cycles", limit);
      end
      check_eq("stb_o high cycles during measurement", stb_high, 0);
   endtask

   // spacing of rising edges and length of the low phase
   task automatic measure_strobe(input int per, input int low_len);
      int   cyc;
      int   low;
      int   k;
      logic prev;
      logic found;
      cyc   = 0;
      found = 1'b0;
      @(negedge clk);
      prev = stb;
      while (!found && cyc < 3 * per) begin
         @(negedge clk);
         cyc++;
         found = (stb === 1'b1 && prev === 1'b0);
         prev  = stb;
      end
      if (!found) begin
         errors++;
         $display("no rising edge on stb_o with the output enabled");
      end else begin
         for (k = 0; k < 2; k++) begin
            cyc   = 0;
            low   = 0;
            found = 1'b0;
            while (!found && cyc < 2 * per) begin
               @(negedge clk);
               cyc++;
               if (stb === 1'b0)
                  low++;
               found = (stb === 1'b1 && prev === 1'b0);
               prev  = stb;
            end
            check_eq("stb_o rising edge spacing", cyc, per);
            check_eq("stb_o low phase", low, low_len);
         end
      end
   endtask

   task automatic check_stb_low(input int cycles, input string what);
      int k;
      int high;
      high = 0;
      for (k = 0; k < cycles; k++) begin
         @(negedge clk);
         if (stb !== 1'b0)
            high++;
      end
      check_eq(what, high, 0);
   endtask

   // random measurement with oe set and then cleared
   task automatic trial();
      n    = 8 + $unsigned($random(seed)) % 53;
      hold = 1 + $unsigned($random(seed)) % (n - 2);
      sig_period <= n;
      repeat (2 * n + 4) @(posedge clk);
      write_reg(ADDR_HOLD, 32'(hold));
      m_hold = hold;
      expect_reg("HOLD", ADDR_HOLD, m_hold);
      run_measure(4 * n + 16);
      m_period = n;
      check_eq("err_o after measurement", int'(err), 0);
      expect_reg("STATUS", ADDR_STATUS, status_word(1, 0, 1));
      expect_reg("PERIOD", ADDR_PERIOD, m_period);
      expect_reg("CTRL with run", ADDR_CTRL, m_oe);
      measure_strobe(n, hold);
      write_reg(ADDR_CTRL, 32'd0);
      m_oe = 0;
      expect_reg("CTRL", ADDR_CTRL, m_oe);
      check_stb_low(n + 2, "stb_o high cycles with oe cleared");
   endtask

   initial begin
      seed       = 92878;
      errors     = 0;
      checks     = 0;
      sig_period = 0;
      phase      = 0;
      arst       = 1'b1;
      sig        = 1'b0;
      apb_req    = '0;
      m_oe       = 0;
      m_hold     = `STB_HOLD_DEFAULT;
      m_period   = 0;
      repeat (8) @(posedge clk);
      arst <= 1'b0;
      @(negedge clk);
      check_eq("rdy_o after reset", int'(rdy), 1);
      check_eq("err_o after reset", int'(err), 0);
      check_eq("stb_o after reset", int'(stb), 0);
      expect_reg("STATUS after reset", ADDR_STATUS, status_word(1, 0, 0));
      expect_reg("HOLD after reset", ADDR_HOLD, m_hold);
      expect_reg("CTRL after reset", ADDR_CTRL, m_oe);
      expect_reg("PERIOD after reset", ADDR_PERIOD, m_period);
      for (t = 0; t < TRIALS; t++)
         trial();
      // unmapped offsets and a read-only register
      apb_access(1'b1, 4'h6, 32'hffff_ffff, rdata, slverr);
      check_eq("pslverr on unmapped write", int'(slverr), 1);
      apb_access(1'b0, 4'hd, 32'd0, rdata, slverr);
      check_eq("pslverr on unmapped read", int'(slverr), 1);
      check_eq("prdata on unmapped read", int'(rdata), 0);
      write_reg(ADDR_PERIOD, 32'hffff_ffff);
      expect_reg("PERIOD after write", ADDR_PERIOD, m_period);
      expect_reg("CTRL after unmapped write", ADDR_CTRL, m_oe);
      expect_reg("HOLD after unmapped write", ADDR_HOLD, m_hold);
      // with no edges the counter saturates
      sig_period <= 0;
      repeat (8) @(posedge clk);
      run_measure(70000);
      check_eq("err_o after overflow", int'(err), 1);
      check_eq("rdy_o after overflow", int'(rdy), 1);
      expect_reg("STATUS after overflow", ADDR_STATUS, status_word(1, 1, 0));
      check_stb_low(64, "stb_o high cycles after overflow");
      // toggling input again clears the error
      n = 8 + $unsigned($random(seed)) % 53;
      sig_period <= n;
      repeat (2 * n + 4) @(posedge clk);
      run_measure(4 * n + 16);
      m_period = n;
      check_eq("err_o after recovery", int'(err), 0);
      expect_reg("PERIOD after recovery", ADDR_PERIOD, m_period);
      expect_reg("STATUS after recovery", ADDR_STATUS, status_word(1, 0, 1));
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: compile.f
+incdir+common
common/stb_pkg.sv
common/apb_pkg.sv
rtl/apb_regs.sv
stb_core/stb_fsm.sv
stb_core/period_timer.sv
stb_core/period_capture.sv
rtl/stb_gen_top.sv
sim/tb_stb_gen.sv

// File: Makefile
# Verilator build for the strobe generator testbench

VERILATOR ?= verilator
TOP       ?= tb_stb_gen
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
